// ==== bench/bridge_tb.sv ====
`timescale 1ns/1ps

`include "bridge_cfg.svh"

module bridge_tb;

  localparam int TIMEOUT = 5000;
  localparam int IDX_W   = $clog2(`REG_COUNT);

  logic       clk;
  logic       reset;
  logic       rx_valid_i;
  logic [7:0] rx_data_i;
  logic       tx_busy_i;
  logic       rx_busy_o;
  logic       tx_valid_o;
  logic [7:0] tx_data_o;
  logic       soft_reset_o;

  logic [31:0] rnd_q  = 32'h86d8_0ce6;  // Addresses and data.
  logic [31:0] busy_q = 32'h86d8_0ce6;  // The tx_busy_i pattern.
  logic        busy_en;
  logic        busy_seen = 1'b0;        // tx_busy_i as the DUT saw it.
  logic        tx_prev   = 1'b0;
  logic [15:0] model [`REG_COUNT];
  logic [7:0]  exp_q [$];
  int          tx_count;
  int          soft_cnt;

  bridge_top UUT (
    .clk          (clk),
    .reset        (reset),
    .rx_valid_i   (rx_valid_i),
    .rx_data_i    (rx_data_i),
    .tx_busy_i    (tx_busy_i),
    .rx_busy_o    (rx_busy_o),
    .tx_valid_o   (tx_valid_o),
    .tx_data_o    (tx_data_o),
    .soft_reset_o (soft_reset_o)
  );

  always #20 clk = ~clk;

  // ============================================================
  // Random source and reference
  // ============================================================

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Register index is the low address bits only.
  function automatic logic [15:0] expected_word(input logic [31:0] addr);
    return model[addr[IDX_W-1:0]];
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v     = {v[30:0], rnd_q[0]};
      rnd_q = lfsr_step(rnd_q);
    end
  endtask

  // ============================================================
  // Checks
  // ============================================================

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  always @(negedge clk) begin
    if (busy_en) begin
      busy_q    = lfsr_step(busy_q);
      tx_busy_i = busy_q[0];
    end else begin
      tx_busy_i = 1'b0;
    end
  end

  always @(posedge clk) busy_seen <= tx_busy_i;

  // Every sent byte must match the head of the queue.
  always @(negedge clk) begin
    if (!reset) begin
      if (busy_seen) check("tx_valid_o after tx_busy_i", 32'(tx_valid_o), 32'h0);
      if (tx_prev) check("tx_valid_o after a sent byte", 32'(tx_valid_o), 32'h0);
    end
    if (!reset && tx_valid_o) begin
      tx_count++;
      if (exp_q.size() == 0) begin
        $display("Unexpected byte 0x%0h on tx_data_o with nothing expected", tx_data_o);
        $display("Simulation failed");
        $fatal(1);
      end else begin
        check("tx_data_o", 32'(tx_data_o), 32'(exp_q.pop_front()));
      end
    end
    if (!reset && soft_reset_o) soft_cnt++;
    tx_prev = tx_valid_o;
  end

  // ============================================================
  // Byte link driver
  // ============================================================

  task automatic send_byte(input logic [7:0] b);
    int n;
    n = 0;
    while (rx_busy_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("rx_busy_o to drop");
    end
    rx_valid_i = 1'b1;
    rx_data_i  = b;
    @(negedge clk);
    rx_valid_i = 1'b0;
  endtask

  task automatic send_nops(input int count);
    for (int i = 0; i < count; i++) send_byte(`CMD_NOP);
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [15:0] data);
    send_byte(`CMD_WRITE);
    for (int i = 0; i < 4; i++) send_byte(addr[8*i +: 8]);
    send_byte(data[7:0]);
    send_byte(data[15:8]);
    check("rx_busy_o", 32'(rx_busy_o), 32'h1);  // Command now pending.
    model[addr[IDX_W-1:0]] = data;
  endtask

  task automatic read_reg(input logic [31:0] addr);
    logic [15:0] w;
    w = expected_word(addr);
    exp_q.push_back(w[7:0]);   // Low byte first.
    exp_q.push_back(w[15:8]);
    send_byte(`CMD_READ);
    for (int i = 0; i < 4; i++) send_byte(addr[8*i +: 8]);
    check("rx_busy_o", 32'(rx_busy_o), 32'h1);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("all expected bytes on tx_data_o");
    end
    repeat (4) @(negedge clk);  // Room for a stray byte.
  endtask

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] sel;
    int          n;
    clk        = 1'b0;
    reset      = 1'b1;
    rx_valid_i = 1'b0;
    rx_data_i  = 8'h00;
    tx_busy_i  = 1'b0;
    busy_en    = 1'b0;
    tx_count   = 0;
    soft_cnt   = 0;
    for (int i = 0; i < `REG_COUNT; i++) model[i] = '0;
    exp_q = '{"m", "o", "n", 8'h0a};
    repeat (10) @(negedge clk);
    check("tx_valid_o", 32'(tx_valid_o), 32'h0);
    check("rx_busy_o", 32'(rx_busy_o), 32'h0);
    check("soft_reset_o", 32'(soft_reset_o), 32'h0);
    reset = 1'b0;
    wait_drain();

    write_reg(32'h0000_0005, 16'hbeef);
    read_reg(32'h0000_0005);
    wait_drain();

    take_bits(32, a);
    take_bits(16, d);
    write_reg(a, d[15:0]);
    read_reg({~a[31:4], a[3:0]});  // Same register, other upper bits.
    wait_drain();

    busy_en = 1'b1;
    for (int i = 0; i < 20; i++) begin
      take_bits(32, a);
      take_bits(16, d);
      write_reg(a, d[15:0]);
      take_bits(1, sel);
      if (!sel[0]) take_bits(32, a);
      read_reg(a);
    end
    wait_drain();
    busy_en = 1'b0;

    // The read breaks the NOP run.
    send_nops(15);
    read_reg(32'h0000_0005);
    send_nops(15);
    repeat (2) @(negedge clk);
    check("soft_reset_o pulse count", soft_cnt, 0);
    send_nops(1);
    n = 0;
    while (soft_cnt == 0) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("the soft_reset_o pulse");
    end
    repeat (4) @(negedge clk);
    check("soft_reset_o pulse count", soft_cnt, 1);
    wait_drain();
    for (int i = 0; i < `REG_COUNT; i++) model[i] = '0;
    for (int i = 0; i < `REG_COUNT; i++) read_reg(32'(i));
    wait_drain();

    n = tx_count;
    send_byte(8'h5a);
    repeat (20) @(negedge clk);
    check("tx byte count", tx_count, n);
    write_reg(32'h0000_000a, 16'h1234);
    read_reg(32'h0000_100a);
    wait_drain();

    if (exp_q.size() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("%0d expected bytes never arrived", exp_q.size());
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/bridge_pkg.sv
rtl/cmd_parser.sv
rtl/apb_requester.sv
rtl/resp_sender.sv
rtl/apb_reg_file.sv
rtl/bridge_top.sv
bench/bridge_tb.sv

// ==== rtl/apb_reg_file.sv ====
`timescale 1ns/1ps

`include "bridge_cfg.svh"

module apb_reg_file (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 soft_rst_i,
  input  bridge_pkg::apb_req_t apb_req_i,
  output bridge_pkg::apb_rsp_t apb_rsp_o
);

  localparam int IDX_W = $clog2(`REG_COUNT);

  logic [15:0]      regs_q [`REG_COUNT];
  logic             wait_q;  // First access cycle done.
  logic             access;
  logic             ready;
  logic [IDX_W-1:0] idx;

  assign access = apb_req_i.psel && apb_req_i.penable;
  assign ready  = access && wait_q;
  assign idx    = apb_req_i.paddr[IDX_W-1:0];  // Upper address bits ignored.

  assign apb_rsp_o.pready = ready;
  assign apb_rsp_o.prdata = regs_q[idx];

  // One wait state per access.
  always_ff @(posedge clk) begin
    if (reset) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= access && !wait_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || soft_rst_i) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (ready && apb_req_i.pwrite) begin
      regs_q[idx] <= apb_req_i.pwdata;
    end
  end

endmodule

// ==== rtl/apb_requester.sv ====
`timescale 1ns/1ps

module apb_requester (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cmd_valid_i,
  input  bridge_pkg::cmd_t     cmd_i,
  input  bridge_pkg::apb_rsp_t apb_rsp_i,
  input  logic                 rsp_ready_i,
  output logic                 cmd_ready_o,
  output bridge_pkg::apb_req_t apb_req_o,
  output logic                 rsp_valid_o,
  output logic [15:0]          rsp_data_o
);

  import bridge_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    HANDOFF
  } state_t;

  state_t      state_q;
  cmd_t        cmd_q;
  logic [15:0] rdata_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:   if (cmd_valid_i) state_q <= SETUP;
        SETUP:  state_q <= ACCESS;
        ACCESS: begin
          if (apb_rsp_i.pready) begin
            state_q <= cmd_q.write ? IDLE : HANDOFF;
          end
        end
        HANDOFF: if (rsp_ready_i) state_q <= IDLE;  // Sender took the word.
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && cmd_valid_i) begin
      cmd_q <= cmd_i;
    end
    if (state_q == ACCESS && apb_rsp_i.pready && !cmd_q.write) begin
      rdata_q <= apb_rsp_i.prdata;
    end
  end

  // New commands only while idle.
  assign cmd_ready_o = (state_q == IDLE);

  assign apb_req_o.psel    = (state_q == SETUP) || (state_q == ACCESS);
  assign apb_req_o.penable = (state_q == ACCESS);
  assign apb_req_o.pwrite  = cmd_q.write;
  assign apb_req_o.paddr   = cmd_q.addr;
  assign apb_req_o.pwdata  = cmd_q.wdata;

  assign rsp_valid_o = (state_q == HANDOFF);
  assign rsp_data_o  = rdata_q;

endmodule

// ==== rtl/bridge_cfg.svh ====
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// Command byte codes.
`define CMD_NOP   8'd0
`define CMD_READ  8'd1
`define CMD_WRITE 8'd2

`define REG_COUNT 16        // 16-bit registers in the file.

`define NOP_RESET_COUNT 16  // Consecutive NOPs for a soft reset.

`define BANNER_LEN 4        // "mon" plus newline.

`endif

// ==== rtl/bridge_pkg.sv ====
package bridge_pkg;

  // ============================================================
  // Parser to requester
  // ============================================================

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [15:0] wdata;
  } cmd_t;

  // ============================================================
  // APB
  // ============================================================

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [15:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [15:0] prdata;
  } apb_rsp_t;

endpackage

// ==== rtl/bridge_top.sv ====
`timescale 1ns/1ps

module bridge_top (
  input  logic       clk,
  input  logic       reset,
  input  logic       rx_valid_i,
  input  logic [7:0] rx_data_i,
  input  logic       tx_busy_i,
  output logic       rx_busy_o,
  output logic       tx_valid_o,
  output logic [7:0] tx_data_o,
  output logic       soft_reset_o
);

  import bridge_pkg::*;

  cmd_t        cmd;
  logic        cmd_valid;
  logic        cmd_ready;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [15:0] rsp_data;

  cmd_parser u_parser (
    .clk         (clk),
    .reset       (reset),
    .rx_valid_i  (rx_valid_i),
    .rx_data_i   (rx_data_i),
    .cmd_ready_i (cmd_ready),
    .rx_busy_o   (rx_busy_o),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd),
    .soft_rst_o  (soft_reset_o)
  );

  apb_requester u_requester (
    .clk         (clk),
    .reset       (reset),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .apb_rsp_i   (apb_rsp),
    .rsp_ready_i (rsp_ready),
    .cmd_ready_o (cmd_ready),
    .apb_req_o   (apb_req),
    .rsp_valid_o (rsp_valid),
    .rsp_data_o  (rsp_data)
  );

  resp_sender u_sender (
    .clk         (clk),
    .reset       (reset),
    .tx_busy_i   (tx_busy_i),
    .rsp_valid_i (rsp_valid),
    .rsp_data_i  (rsp_data),
    .rsp_ready_o (rsp_ready),
    .tx_valid_o  (tx_valid_o),
    .tx_data_o   (tx_data_o)
  );

  // Soft reset clears the register file.
  apb_reg_file u_reg_file (
    .clk        (clk),
    .reset      (reset),
    .soft_rst_i (soft_reset_o),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp)
  );

endmodule

// ==== rtl/cmd_parser.sv ====
`timescale 1ns/1ps

`include "bridge_cfg.svh"

module cmd_parser (
  input  logic             clk,
  input  logic             reset,
  input  logic             rx_valid_i,
  input  logic [7:0]       rx_data_i,
  input  logic             cmd_ready_i,
  output logic             rx_busy_o,
  output logic             cmd_valid_o,
  output bridge_pkg::cmd_t cmd_o,
  output logic             soft_rst_o
);

  localparam int NOP_W = $clog2(`NOP_RESET_COUNT);

  typedef enum logic [1:0] {
    COMMAND,
    ADDRESS,
    DATA
  } state_t;

  state_t           state_q;
  logic [1:0]       byte_q;     // Byte position within address or data.
  logic [NOP_W-1:0] nop_cnt_q;
  logic             accept;

  // Bytes offered while a command is pending are dropped.
  assign accept    = rx_valid_i && !cmd_valid_o;
  assign rx_busy_o = cmd_valid_o;

  // ============================================================
  // Control
  // ============================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q     <= COMMAND;
      byte_q      <= 2'd0;
      nop_cnt_q   <= '0;
      cmd_valid_o <= 1'b0;
      soft_rst_o  <= 1'b0;
    end else begin
      soft_rst_o <= 1'b0;
      if (cmd_valid_o && cmd_ready_i) begin
        cmd_valid_o <= 1'b0;
      end
      if (accept) begin
        case (state_q)
          COMMAND: begin
            byte_q <= 2'd0;
            case (rx_data_i)
              `CMD_READ, `CMD_WRITE: begin
                nop_cnt_q <= '0;
                state_q   <= ADDRESS;
              end
              `CMD_NOP: begin
                if (nop_cnt_q == NOP_W'(`NOP_RESET_COUNT - 1)) begin
                  soft_rst_o <= 1'b1;
                  nop_cnt_q  <= '0;
                end else begin
                  nop_cnt_q <= nop_cnt_q + 1'b1;
                end
              end
              default: nop_cnt_q <= '0;  // Unknown byte breaks the NOP run.
            endcase
          end
          ADDRESS: begin
            byte_q <= byte_q + 1'b1;
            if (byte_q == 2'd3) begin
              if (cmd_o.write) begin
                state_q <= DATA;
              end else begin
                state_q     <= COMMAND;
                cmd_valid_o <= 1'b1;
              end
            end
          end
          DATA: begin
            byte_q <= byte_q + 1'b1;
            if (byte_q[0]) begin
              state_q     <= COMMAND;
              cmd_valid_o <= 1'b1;
            end
          end
          default: state_q <= COMMAND;
        endcase
      end
    end
  end

  // ============================================================
  // Command payload, low byte first
  // ============================================================

  always_ff @(posedge clk) begin
    if (accept) begin
      case (state_q)
        COMMAND: cmd_o.write <= (rx_data_i == `CMD_WRITE);
        ADDRESS: cmd_o.addr[8*byte_q +: 8] <= rx_data_i;
        DATA:    cmd_o.wdata[8*byte_q[0] +: 8] <= rx_data_i;
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/resp_sender.sv ====
`timescale 1ns/1ps

`include "bridge_cfg.svh"

module resp_sender (
  input  logic        clk,
  input  logic        reset,
  input  logic        tx_busy_i,
  input  logic        rsp_valid_i,
  input  logic [15:0] rsp_data_i,
  output logic        rsp_ready_o,
  output logic        tx_valid_o,
  output logic [7:0]  tx_data_o
);

  localparam int CNT_W = $clog2(`BANNER_LEN);
  localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`BANNER_LEN - 1);

  localparam logic [7:0] BANNER_TEXT [`BANNER_LEN] = '{"m", "o", "n", 8'h0a};

  typedef enum logic [1:0] {
    BANNER,
    IDLE,
    SEND
  } state_t;

  state_t           state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             hi_q;      // High byte is next.
  logic [15:0]      word_q;
  logic             can_send;

  // Gap cycle after every byte.
  assign can_send    = !tx_busy_i && !tx_valid_o;
  assign rsp_ready_o = (state_q == IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= BANNER;
      cnt_q      <= '0;
      hi_q       <= 1'b0;
      tx_valid_o <= 1'b0;
    end else begin
      tx_valid_o <= 1'b0;
      case (state_q)
        BANNER: begin
          if (can_send) begin
            tx_valid_o <= 1'b1;
            cnt_q      <= cnt_q + 1'b1;
            if (cnt_q == LAST_IDX) state_q <= IDLE;
          end
        end
        IDLE: begin
          if (rsp_valid_i) begin
            state_q <= SEND;
            hi_q    <= 1'b0;
          end
        end
        SEND: begin
          if (can_send) begin
            tx_valid_o <= 1'b1;
            hi_q       <= 1'b1;
            if (hi_q) state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && rsp_valid_i) begin
      word_q <= rsp_data_i;
    end
    if (can_send) begin
      if (state_q == BANNER) begin
        tx_data_o <= BANNER_TEXT[cnt_q];
      end else if (state_q == SEND) begin
        tx_data_o <= hi_q ? word_q[15:8] : word_q[7:0];  // Low byte first.
      end
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module bridge_tb -o bridge_sim

out=$(./obj_dir/bridge_sim || true)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi
